// ==== hdl/oram_defs.svh ====
// ====================================================================
// ORAM path address generator configuration
// tree depth, subtree height, burst counts and DRAM address width
// ====================================================================

`ifndef ORAM_DEFS_SVH
`define ORAM_DEFS_SVH

// leaf level L, the tree has L+1 levels
`define oramLevels 5

// levels per subtree
// keep (oramLevels + 1) a multiple of this so physical indices stay in range
`define subtreeLevels 2

// bursts per full bucket
`define bktBursts 4

// bursts for a header-only access
`define bktHdrBursts 1

// address step per DRAM burst
`define ddrBurstLen 8

// DRAM address width
`define ddrAddrWidth 27

`endif

// ==== hdl/oramPkg.sv ====
// ====================================================================
// ORAM address generator types
// commands, tree levels, bucket indices and burst numbers
// ====================================================================

`default_nettype none

`include "oram_defs.svh"

package oramPkg;

	localparam int LevelW = $clog2(`oramLevels + 1);
	localparam int BurstW = (`bktBursts > 1) ? $clog2(`bktBursts) : 1;

	// DRAM command, one bit on the wire
	typedef enum logic {
		cmdWrite = 1'b0,
		cmdRead  = 1'b1
	} ddrCmd_t;

	typedef logic [LevelW-1:0] level_t;
	// heap style bucket index, root is 0
	typedef logic [`oramLevels:0] bktIdx_t;
	typedef logic [`oramLevels-1:0] leaf_t;
	typedef logic [BurstW-1:0] burstIdx_t;

endpackage

`default_nettype wire

// ==== hdl/pathWalker.sv ====
// ====================================================================
// Path walker, stage 1
// latches a request and steps from the root down to the leaf,
// giving the logical and subtree-mapped physical bucket index
// ====================================================================

`default_nettype none

`include "oram_defs.svh"

module pathWalker (
	input  wire                     Clock,
	input  wire                     arstN,
	input  wire                     Start,
	input  wire oramPkg::leaf_t     Leaf,
	input  wire                     ReadNotWrite,
	input  wire                     HeaderOnly,
	input  wire                     BktDone,
	output logic                    Idle,
	output logic                    BktValid,
	output logic                    Read,
	output logic                    Header,
	output oramPkg::bktIdx_t        PhysIdx,
	output oramPkg::bktIdx_t        LogIdx
);

	import oramPkg::*;

	localparam int SubK = `subtreeLevels;
	localparam int DepthW = $clog2(SubK + 1);
	// buckets in one full subtree
	localparam bktIdx_t StSize = bktIdx_t'((1 << SubK) - 1);
	// first node of the bottom row inside a subtree
	localparam bktIdx_t RowBase = bktIdx_t'((1 << (SubK - 1)) - 1);
	localparam level_t LastLevel = level_t'(`oramLevels);
	localparam logic [DepthW-1:0] LastDepth = DepthW'(SubK - 1);

	logic busy;
	level_t level;
	leaf_t leafReg;
	logic readReg;
	logic headerReg;
	bktIdx_t logIdx;
	bktIdx_t stNum;
	bktIdx_t stNode;
	logic [DepthW-1:0] stDepth;
	logic dirBit;
	bktIdx_t bottomPos;

	// leaf bit for this level picks the child, bit 0 first
	assign dirBit = (level < LastLevel) ? leafReg[level] : 1'b0;
	assign bottomPos = stNode - RowBase;

	// ================================================================
	// level and index stepping
	// ================================================================
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			busy <= 1'b0;
			level <= '0;
			logIdx <= '0;
			stNum <= '0;
			stNode <= '0;
			stDepth <= '0;
		end else if (Start && !busy) begin
			busy <= 1'b1;
			level <= '0;
			logIdx <= '0;
			stNum <= '0;
			stNode <= '0;
			stDepth <= '0;
		end else if (BktDone && busy) begin
			if (level == LastLevel) begin
				// leaf bucket finished
				busy <= 1'b0;
			end else begin
				level <= level_t'(level + 1'b1);
				logIdx <= (logIdx << 1) + bktIdx_t'(1) + bktIdx_t'(dirBit);
				if (stDepth == LastDepth) begin
					// leave through the bottom row into a child subtree
					stNum <= (stNum << SubK) + bktIdx_t'(1) + (bottomPos << 1)
						+ bktIdx_t'(dirBit);
					stNode <= '0;
					stDepth <= '0;
				end else begin
					stNode <= (stNode << 1) + bktIdx_t'(1) + bktIdx_t'(dirBit);
					stDepth <= stDepth + 1'b1;
				end
			end
		end
	end

	// request bits, held for the whole path
	always_ff @(posedge Clock) begin
		if (Start && !busy) begin
			leafReg <= Leaf;
			readReg <= ReadNotWrite;
			headerReg <= HeaderOnly;
		end
	end

	assign Idle = !busy;
	assign BktValid = busy;
	assign Read = readReg;
	assign Header = headerReg;
	assign LogIdx = logIdx;
	// subtrees sit back to back in memory
	assign PhysIdx = stNum * StSize + stNode;

endmodule

`default_nettype wire

// ==== hdl/bucketBurstSeq.sv ====
// ====================================================================
// Bucket burst sequencer, stage 2
// expands the current bucket into DRAM bursts
// ====================================================================

`default_nettype none

`include "oram_defs.svh"

module bucketBurstSeq (
	input  wire                       Clock,
	input  wire                       arstN,
	input  wire                       BktValid,
	input  wire oramPkg::bktIdx_t     PhysIdx,
	input  wire oramPkg::bktIdx_t     LogIdx,
	input  wire                       Read,
	input  wire                       Header,
	input  wire                       Advance,
	output logic                      BktDone,
	output logic                      BurstValid,
	output oramPkg::bktIdx_t          BurstPhysIdx,
	output oramPkg::burstIdx_t        BurstNum,
	output logic                      BurstRead,
	output oramPkg::bktIdx_t          BurstLogIdx
);

	import oramPkg::*;

	localparam burstIdx_t FullLast = burstIdx_t'(`bktBursts - 1);
	localparam burstIdx_t HdrLast = burstIdx_t'(`bktHdrBursts - 1);

	burstIdx_t burstCnt;
	burstIdx_t burstLast;
	logic take;
	logic lastBurst;

	// header accesses stop early
	assign burstLast = Header ? HdrLast : FullLast;
	assign take = BktValid && Advance;
	assign lastBurst = (burstCnt == burstLast);

	// counter only moves when stage 3 takes a burst
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			burstCnt <= '0;
		end else if (take) begin
			if (lastBurst)
				burstCnt <= '0;
			else
				burstCnt <= burstCnt + 1'b1;
		end
	end

	// walker steps on the same edge, so no bubble between buckets
	assign BktDone = take && lastBurst;

	assign BurstValid = BktValid;
	assign BurstNum = burstCnt;
	assign BurstPhysIdx = PhysIdx;
	assign BurstLogIdx = LogIdx;
	assign BurstRead = Read;

endmodule

`default_nettype wire

// ==== hdl/dramCmdFormer.sv ====
// ====================================================================
// DRAM command former, stage 3
// one-entry output register holding command, address and bucket
// ====================================================================

`default_nettype none

`include "oram_defs.svh"

module dramCmdFormer (
	input  wire                       Clock,
	input  wire                       arstN,
	input  wire                       BurstValid,
	input  wire oramPkg::bktIdx_t     BurstPhysIdx,
	input  wire oramPkg::burstIdx_t   BurstNum,
	input  wire                       BurstRead,
	input  wire oramPkg::bktIdx_t     BurstLogIdx,
	input  wire                       CmdReady,
	output logic                      Advance,
	output logic                      CmdValid,
	output oramPkg::ddrCmd_t          Cmd,
	output logic [`ddrAddrWidth-1:0]  Addr,
	output oramPkg::bktIdx_t          BktIdx
);

	import oramPkg::*;

	localparam int AddrW = `ddrAddrWidth;

	logic occupied;
	logic load;
	logic [AddrW-1:0] addrNext;

	// free now, or emptied by the DRAM side this cycle
	assign Advance = !occupied || CmdReady;
	assign load = BurstValid && Advance;

	// bucket base in bursts, plus burst offset, scaled to bytes
	assign addrNext = (AddrW'(BurstPhysIdx) * AddrW'(`bktBursts) + AddrW'(BurstNum))
		* AddrW'(`ddrBurstLen);

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN)
			occupied <= 1'b0;
		else if (load)
			occupied <= 1'b1;
		else if (CmdReady)
			occupied <= 1'b0;
	end

	// held steady under back-pressure since load needs Advance
	always_ff @(posedge Clock) begin
		if (load) begin
			Cmd <= BurstRead ? cmdRead : cmdWrite;
			Addr <= addrNext;
			BktIdx <= BurstLogIdx;
		end
	end

	assign CmdValid = occupied;

endmodule

`default_nettype wire

// ==== hdl/addrGen.sv ====
// ====================================================================
// ORAM path address generator
// turns a path request into one DRAM command per bucket burst
// ====================================================================

`default_nettype none

`include "oram_defs.svh"

module addrGen (
	input  wire                       Clock,
	input  wire                       arstN,
	input  wire                       Start,
	input  wire oramPkg::leaf_t       Leaf,
	input  wire                       ReadNotWrite,
	input  wire                       HeaderOnly,
	output logic                      Ready,
	input  wire                       CmdReady,
	output logic                      CmdValid,
	output oramPkg::ddrCmd_t          Cmd,
	output logic [`ddrAddrWidth-1:0]  Addr,
	output oramPkg::bktIdx_t          BktIdx
);

	import oramPkg::*;

	logic startAccept;
	logic idle;
	logic bktValid;
	logic read;
	logic header;
	bktIdx_t physIdx;
	bktIdx_t logIdx;
	logic bktDone;
	logic advance;
	logic burstValid;
	bktIdx_t burstPhysIdx;
	burstIdx_t burstNum;
	logic burstRead;
	bktIdx_t burstLogIdx;

	// a Start while busy is dropped here
	assign startAccept = Start && Ready;

	// ================================================================
	// stage 1, path walk
	// ================================================================
	pathWalker walker0 (
		.Clock        (Clock),
		.arstN        (arstN),
		.Start        (startAccept),
		.Leaf         (Leaf),
		.ReadNotWrite (ReadNotWrite),
		.HeaderOnly   (HeaderOnly),
		.BktDone      (bktDone),
		.Idle         (idle),
		.BktValid     (bktValid),
		.Read         (read),
		.Header       (header),
		.PhysIdx      (physIdx),
		.LogIdx       (logIdx)
	);

	// stage 2, bursts per bucket
	bucketBurstSeq burstSeq0 (
		.Clock        (Clock),
		.arstN        (arstN),
		.BktValid     (bktValid),
		.PhysIdx      (physIdx),
		.LogIdx       (logIdx),
		.Read         (read),
		.Header       (header),
		.Advance      (advance),
		.BktDone      (bktDone),
		.BurstValid   (burstValid),
		.BurstPhysIdx (burstPhysIdx),
		.BurstNum     (burstNum),
		.BurstRead    (burstRead),
		.BurstLogIdx  (burstLogIdx)
	);

	// stage 3, output register
	dramCmdFormer cmdFormer0 (
		.Clock        (Clock),
		.arstN        (arstN),
		.BurstValid   (burstValid),
		.BurstPhysIdx (burstPhysIdx),
		.BurstNum     (burstNum),
		.BurstRead    (burstRead),
		.BurstLogIdx  (burstLogIdx),
		.CmdReady     (CmdReady),
		.Advance      (advance),
		.CmdValid     (CmdValid),
		.Cmd          (Cmd),
		.Addr         (Addr),
		.BktIdx       (BktIdx)
	);

	// done once the walker is idle and the last command has left
	assign Ready = idle && !CmdValid;

endmodule

`default_nettype wire

// ==== verification/addrGenChecker.sv ====
// ====================================================================
// Output protocol checker for the ORAM path address generator
// watches Ready and the DRAM command port from inside the top level
// ====================================================================

`default_nettype none

`include "oram_defs.svh"

module addrGenChecker (
	input wire                      Clock,
	input wire                      arstN,
	input wire                      Start,
	input wire                      Ready,
	input wire                      CmdValid,
	input wire                      CmdReady,
	input wire oramPkg::ddrCmd_t    Cmd,
	input wire [`ddrAddrWidth-1:0]  Addr,
	input wire oramPkg::bktIdx_t    BktIdx
);

	timeunit 1ns;
	timeprecision 100ps;

	// number of failed assertions so far
	int violations = 0;

	// ================================================================
	// output port rules
	// ================================================================
	// an idle generator stays idle until a Start arrives
	property readyHeldWithoutStart;
		@(posedge Clock) disable iff (!arstN)
		Ready && !Start |=> Ready;
	endproperty

	// command held steady while the DRAM side stalls
	property holdUnderBackPressure;
		@(posedge Clock) disable iff (!arstN)
		CmdValid && !CmdReady |=>
			CmdValid && $stable(Cmd) && $stable(Addr) && $stable(BktIdx);
	endproperty

	property readyAfterReset;
		@(posedge Clock) $rose(arstN) |-> Ready;
	endproperty

	readyHeldWithoutStartA: assert property (readyHeldWithoutStart)
	else begin
		violations++;
		$error("Ready fell without a Start");
	end

	holdUnderBackPressureA: assert property (holdUnderBackPressure)
	else begin
		violations++;
		$error("command changed or dropped while CmdReady was low");
	end

	readyAfterResetA: assert property (readyAfterReset)
	else begin
		violations++;
		$error("Ready is low in the first cycle after reset");
	end

endmodule

`default_nettype wire

// ==== verification/addrGenTb.sv ====
// ====================================================================
// Testbench for the ORAM path address generator
// applies a table of path requests and checks every DRAM command
// against a model of the heap rule and the subtree layout
// ====================================================================

`default_nettype none

`include "oram_defs.svh"

module addrGenTb;

	timeunit 1ns;
	timeprecision 100ps;

	import oramPkg::*;

	localparam int NumRows = 8;
	localparam int Levels = `oramLevels;
	localparam int SubK = `subtreeLevels;
	localparam int AddrW = `ddrAddrWidth;
	localparam int ClockPeriod = 4;
	localparam int ResetCycles = 10;
	localparam int WatchdogCycles = NumRows * (Levels + 1) * `bktBursts * 20;
	localparam int NumBuckets = (1 << (Levels + 1)) - 1;
	// one slot for every burst of every bucket
	localparam int AddrSlots = NumBuckets * `bktBursts;

	typedef struct packed {
		leaf_t       leaf;
		logic        readNotWrite;
		logic        headerOnly;
		logic        randomReady;
		logic        spuriousStart;
		logic [15:0] cmdCount;
	} testRow_t;

	logic Clock;
	logic arstN;
	logic Start;
	leaf_t Leaf;
	logic ReadNotWrite;
	logic HeaderOnly;
	logic Ready;
	logic CmdReady;
	logic CmdValid;
	ddrCmd_t Cmd;
	logic [AddrW-1:0] Addr;
	bktIdx_t BktIdx;

	testRow_t rows [NumRows];
	int rowCount;
	integer seed = 66;
	logic randomReady;
	int acceptedCount;
	// owning logical bucket plus one for each burst address
	// zero marks an unused slot
	int ownerOf [AddrSlots];
	logic expCmd [$];
	logic [AddrW-1:0] expAddr [$];
	bktIdx_t expBkt [$];
	logic wantCmd;
	logic [AddrW-1:0] wantAddr;
	bktIdx_t wantBkt;

	addrGen dut0 (
		.Clock        (Clock),
		.arstN        (arstN),
		.Start        (Start),
		.Leaf         (Leaf),
		.ReadNotWrite (ReadNotWrite),
		.HeaderOnly   (HeaderOnly),
		.Ready        (Ready),
		.CmdReady     (CmdReady),
		.CmdValid     (CmdValid),
		.Cmd          (Cmd),
		.Addr         (Addr),
		.BktIdx       (BktIdx)
	);

	bind addrGen addrGenChecker checker0 (
		.Clock    (Clock),
		.arstN    (arstN),
		.Start    (Start),
		.Ready    (Ready),
		.CmdValid (CmdValid),
		.CmdReady (CmdReady),
		.Cmd      (Cmd),
		.Addr     (Addr),
		.BktIdx   (BktIdx)
	);

	always #(ClockPeriod / 2) Clock = ~Clock;

	// DRAM side with optional random stalls
	always @(posedge Clock) begin
		if (!arstN)
			CmdReady <= 1'b0;
		else if (randomReady)
			CmdReady <= 1'($random(seed));
		else
			CmdReady <= 1'b1;
	end

	task automatic stopWithError(input string why);
		$display("Error at %0t ns: %s", $time, why);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic compareValue(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic addRow(input leaf_t leaf, input logic rnw, input logic hdr,
		input logic rnd, input logic spur);
		testRow_t row;
		row.leaf = leaf;
		row.readNotWrite = rnw;
		row.headerOnly = hdr;
		row.randomReady = rnd;
		row.spuriousStart = spur;
		row.cmdCount = 16'((Levels + 1) * (hdr ? `bktHdrBursts : `bktBursts));
		rows[rowCount] = row;
		rowCount++;
	endtask

	// ================================================================
	// reference model of the path and the subtree layout
	// ================================================================
	task automatic predictPath(input testRow_t row);
		int lvl;
		int j;
		int b;
		int nb;
		int pos;
		int logical;
		int stLevel;
		int depth;
		int stNum;
		int phys;
		int slot;
		nb = row.headerOnly ? `bktHdrBursts : `bktBursts;
		pos = 0;
		for (lvl = 0; lvl <= Levels; lvl++) begin
			// path position so far with the first leaf bit as MSB
			if (lvl > 0)
				pos = pos * 2 + row.leaf[lvl - 1];
			logical = (1 << lvl) - 1 + pos;
			stLevel = lvl / SubK;
			depth = lvl % SubK;
			// breadth-first subtree number counts all shallower subtrees first
			stNum = pos >> depth;
			for (j = 0; j < stLevel; j++)
				stNum = stNum + (1 << (SubK * j));
			phys = stNum * ((1 << SubK) - 1) + (1 << depth) - 1 + (pos & ((1 << depth) - 1));
			if (phys >= NumBuckets)
				stopWithError($sformatf("model physical index %0d out of range", phys));
			for (b = 0; b < nb; b++) begin
				slot = phys * `bktBursts + b;
				if (ownerOf[slot] != 0 && ownerOf[slot] != logical + 1)
					stopWithError($sformatf("buckets %0d and %0d share address slot %0d",
						ownerOf[slot] - 1, logical, slot));
				ownerOf[slot] = logical + 1;
				expCmd.push_back(row.readNotWrite);
				expAddr.push_back(AddrW'(slot * `ddrBurstLen));
				expBkt.push_back(bktIdx_t'(logical));
			end
		end
	endtask

	task automatic runRow(input testRow_t row);
		int pending;
		int cyc;
		logic done;
		predictPath(row);
		compareValue("predicted command count", expAddr.size(), row.cmdCount);
		@(posedge Clock);
		acceptedCount = 0;
		Start <= 1'b1;
		Leaf <= row.leaf;
		ReadNotWrite <= row.readNotWrite;
		HeaderOnly <= row.headerOnly;
		randomReady <= row.randomReady;
		@(posedge Clock);
		Start <= 1'b0;
		pending = row.cmdCount;
		cyc = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge Clock);
			compareValue("Ready", Ready, pending == 0);
			// first burst reaches the output on the second edge after Start
			if (cyc == 0)
				compareValue("CmdValid", CmdValid, 1'b0);
			if (cyc == 1 && !row.randomReady)
				compareValue("CmdValid", CmdValid, 1'b1);
			if (pending == 0)
				done = 1'b1;
			else if (CmdValid && CmdReady)
				pending = pending - 1;
			if (row.spuriousStart && cyc == 1) begin
				@(posedge Clock);
				Start <= 1'b1;
				Leaf <= ~row.leaf;
				ReadNotWrite <= ~row.readNotWrite;
				HeaderOnly <= ~row.headerOnly;
			end else if (row.spuriousStart && cyc == 2) begin
				@(posedge Clock);
				Start <= 1'b0;
			end
			cyc++;
		end
		compareValue("accepted command count", acceptedCount, row.cmdCount);
		compareValue("commands left in model", expAddr.size(), 0);
	endtask

	// ================================================================
	// command monitor
	// ================================================================
	always @(negedge Clock) begin
		if (arstN && dut0.checker0.violations != 0)
			stopWithError("an output protocol assertion failed");
		if (arstN && CmdValid && CmdReady) begin
			if (expAddr.size() == 0)
				stopWithError("DRAM command accepted when none was expected");
			wantCmd = expCmd.pop_front();
			wantAddr = expAddr.pop_front();
			wantBkt = expBkt.pop_front();
			compareValue("Cmd", Cmd, wantCmd);
			compareValue("Addr", Addr, wantAddr);
			compareValue("BktIdx", BktIdx, wantBkt);
			acceptedCount++;
		end
	end

	initial begin
		repeat (WatchdogCycles + ResetCycles) @(posedge Clock);
		stopWithError($sformatf("timeout, requests not finished after %0d cycles",
			WatchdogCycles + ResetCycles));
	end

	initial begin
		int i;
		Clock = 1'b0;
		arstN = 1'b0;
		Start = 1'b0;
		Leaf = '0;
		ReadNotWrite = 1'b0;
		HeaderOnly = 1'b0;
		CmdReady = 1'b0;
		randomReady = 1'b0;
		rowCount = 0;
		acceptedCount = 0;
		for (i = 0; i < AddrSlots; i++)
			ownerOf[i] = 0;
		// leaf, read, header, random stalls, spurious Start
		addRow(5'b00000, 1'b0, 1'b0, 1'b0, 1'b0);
		addRow(5'b11111, 1'b0, 1'b0, 1'b0, 1'b0);
		addRow(5'b01101, 1'b1, 1'b1, 1'b0, 1'b0);
		addRow(5'b10010, 1'b1, 1'b1, 1'b0, 1'b1);
		addRow(5'b00111, 1'b0, 1'b0, 1'b1, 1'b0);
		addRow(5'b11000, 1'b1, 1'b0, 1'b1, 1'b1);
		addRow(5'b10101, 1'b1, 1'b1, 1'b1, 1'b0);
		addRow(5'b01010, 1'b0, 1'b0, 1'b0, 1'b1);
		repeat (ResetCycles) @(posedge Clock);
		arstN <= 1'b1;
		@(posedge Clock);
		@(negedge Clock);
		compareValue("Ready after reset", Ready, 1'b1);
		for (i = 0; i < rowCount; i++)
			runRow(rows[i]);
		// nothing may follow the last request
		repeat (4) begin
			@(negedge Clock);
			compareValue("Ready when idle", Ready, 1'b1);
			compareValue("CmdValid when idle", CmdValid, 1'b0);
		end
		if (dut0.checker0.violations == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			$display("Simulation failed");
			$fatal(1, "output protocol checker reported a violation");
		end
	end

endmodule

`default_nettype wire

// ==== addrGen.f ====
+incdir+hdl
hdl/oramPkg.sv
hdl/pathWalker.sv
hdl/bucketBurstSeq.sv
hdl/dramCmdFormer.sv
hdl/addrGen.sv
verification/addrGenChecker.sv
verification/addrGenTb.sv
